/* hdl/sram_test_pkg.sv */
// shared sizes for the sram self-test
// fsm state encodings for the controller and the tester
// 36-bit pattern step function
`default_nettype none

package sram_test_pkg;

   // memory geometry
   localparam int sram_addr_w = 8;
   localparam int sram_data_w = 36;
   localparam logic [sram_addr_w-1:0] stop_addr = {sram_addr_w{1'b1}};

   // cycles from addr on the pins to valid rd_data
   localparam int rd_latency = 4;

   // error log and counters
   localparam int log_depth = 4;
   localparam int log_ptr_w = $clog2(log_depth);
   localparam int log_cnt_w = 16;
   localparam int pass_cnt_w = 4;

   // tester fsm
   localparam logic [1:0] tst_idle = 2'd0;
   localparam logic [1:0] tst_write = 2'd1;
   localparam logic [1:0] tst_read = 2'd2;

   // controller fsm
   localparam logic [1:0] ctrl_idle = 2'd0;
   localparam logic [1:0] ctrl_launch = 2'd1;
   localparam logic [1:0] ctrl_wait = 2'd2;

   // shift left, the nor term pulls the register out of all zeros
   function automatic logic [sram_data_w-1:0] lfsr_next(input logic [sram_data_w-1:0] cur);
      logic fb;
      fb = cur[35] ^ cur[24] ^ ~(|cur[34:0]);
      return {cur[34:0], fb};
   endfunction

endpackage

`default_nettype wire

/* hdl/sram_test_ctrl.sv */
// multi-pass test sequencer
// launches one tester pass at a time and chains the seeds
// keeps pass ok / pass fail counters and the sticky run fail flag
`timescale 1ns/1ns
`default_nettype none

module sram_test_ctrl (
   input  wire logic                                   clk,
   input  wire logic                                   reset,
   input  wire logic                                   start,
   input  wire logic [sram_test_pkg::sram_data_w-1:0]  seed,
   input  wire logic [sram_test_pkg::pass_cnt_w-1:0]   num_passes,
   output logic                                        busy,
   output logic                                        done,
   output logic                                        fail,
   output logic [sram_test_pkg::log_cnt_w-1:0]         pass_ok_count,
   output logic [sram_test_pkg::log_cnt_w-1:0]         pass_fail_count,
   output logic                                        tst_start,
   output logic [sram_test_pkg::sram_data_w-1:0]       tst_seed,
   input  wire logic                                   tst_done,
   input  wire logic                                   tst_fail,
   output logic                                        run_clear
);

   logic [1:0]                              state;
   logic [sram_test_pkg::pass_cnt_w-1:0]    passes_left;
   logic [sram_test_pkg::sram_data_w-1:0]   cur_seed;

   assign busy = (state != sram_test_pkg::ctrl_idle);
   assign tst_start = (state == sram_test_pkg::ctrl_launch);
   assign tst_seed = cur_seed;

   ////////////////////////////////////////
   // pass sequencing
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= sram_test_pkg::ctrl_idle;
         passes_left <= '0;
         done <= 1'b0;
         fail <= 1'b0;
         run_clear <= 1'b0;
         pass_ok_count <= '0;
         pass_fail_count <= '0;
      end else begin
         done <= 1'b0;
         run_clear <= 1'b0;
         case (state)
            sram_test_pkg::ctrl_idle: begin
               // start while busy never reaches here
               if (start) begin
                  passes_left <= (num_passes == '0) ? 1 : num_passes;
                  fail <= 1'b0;
                  run_clear <= 1'b1;
                  pass_ok_count <= '0;
                  pass_fail_count <= '0;
                  state <= sram_test_pkg::ctrl_launch;
               end
            end
            sram_test_pkg::ctrl_launch: begin
               state <= sram_test_pkg::ctrl_wait;
            end
            sram_test_pkg::ctrl_wait: begin
               if (tst_done) begin
                  fail <= fail | tst_fail;
                  if (tst_fail) begin
                     pass_fail_count <= pass_fail_count + 1'b1;
                  end else begin
                     pass_ok_count <= pass_ok_count + 1'b1;
                  end
                  passes_left <= passes_left - 1'b1;
                  if (passes_left == 1) begin
                     done <= 1'b1;
                     state <= sram_test_pkg::ctrl_idle;
                  end else begin
                     state <= sram_test_pkg::ctrl_launch;
                  end
               end
            end
            default: begin
               state <= sram_test_pkg::ctrl_idle;
            end
         endcase
      end
   end

   // seed chain, next pass uses the step of this one
   always_ff @(posedge clk) begin
      if (state == sram_test_pkg::ctrl_idle && start) begin
         cur_seed <= seed;
      end else if (state == sram_test_pkg::ctrl_wait && tst_done) begin
         cur_seed <= sram_test_pkg::lfsr_next(cur_seed);
      end
   end

endmodule

`default_nettype wire

/* hdl/sram_rand_pat_tester.sv */
// pseudo-random pattern tester for one pass over the sram
// write sweep then read sweep, one access per cycle
// access pipeline carrying op, address and expected word
// read compare with mismatch records to the error log
`timescale 1ns/1ns
`default_nettype none

module sram_rand_pat_tester (
   input  wire logic                                   clk,
   input  wire logic                                   reset,
   input  wire logic                                   tst_start,
   input  wire logic [sram_test_pkg::sram_data_w-1:0]  tst_seed,
   output logic                                        tst_done,
   output logic                                        tst_fail,
   output logic [sram_test_pkg::sram_addr_w-1:0]       addr,
   output logic                                        we_n,
   output logic [sram_test_pkg::sram_data_w-1:0]       wr_data,
   output logic                                        tri_en,
   input  wire logic [sram_test_pkg::sram_data_w-1:0]  rd_data,
   output logic                                        log_vld,
   output logic [sram_test_pkg::sram_addr_w-1:0]       log_addr,
   output logic [sram_test_pkg::sram_data_w-1:0]       log_exp_data,
   output logic [sram_test_pkg::sram_data_w-1:0]       log_rd_data
);

   localparam int lat = sram_test_pkg::rd_latency;

   logic [1:0]                              state;
   logic [1:0]                              state_nxt;
   logic [sram_test_pkg::sram_addr_w-1:0]   sm_addr;
   logic [sram_test_pkg::sram_addr_w-1:0]   sm_addr_nxt;
   logic [sram_test_pkg::sram_data_w-1:0]   pat;
   logic [sram_test_pkg::sram_data_w-1:0]   pat_nxt;
   logic [sram_test_pkg::sram_data_w-1:0]   seed_q;
   logic                                    fail_nxt;
   logic                                    done_nxt;

   // access issued this cycle
   logic                                    acc_vld;
   logic                                    acc_wr;
   logic [sram_test_pkg::sram_data_w-1:0]   acc_data;

   // stage i lines up with addr i cycles after it was driven
   logic [lat:0]                            pipe_vld;
   logic [lat:0]                            pipe_rd;
   logic [sram_test_pkg::sram_addr_w-1:0]   pipe_addr [0:lat];
   logic [sram_test_pkg::sram_data_w-1:0]   pipe_data [0:lat];

   logic                                    wr_stage;
   logic                                    chk_vld;
   logic                                    chk_fail;
   logic                                    last_rd;

   ////////////////////////////////////////
   // sweep fsm
   ////////////////////////////////////////
   always_comb begin
      state_nxt = state;
      sm_addr_nxt = sm_addr;
      pat_nxt = pat;
      acc_vld = 1'b0;
      acc_wr = 1'b0;
      acc_data = pat;
      fail_nxt = tst_fail;
      done_nxt = 1'b0;
      case (state)
         sram_test_pkg::tst_idle: begin
            if (tst_start) begin
               // seed goes to address 0
               fail_nxt = 1'b0;
               acc_vld = 1'b1;
               acc_wr = 1'b1;
               acc_data = tst_seed;
               sm_addr_nxt = '0;
               pat_nxt = sram_test_pkg::lfsr_next(tst_seed);
               state_nxt = sram_test_pkg::tst_write;
            end
         end
         sram_test_pkg::tst_write: begin
            acc_vld = 1'b1;
            if (sm_addr == sram_test_pkg::stop_addr) begin
               // first read, pattern restarts from the seed
               acc_data = seed_q;
               sm_addr_nxt = '0;
               pat_nxt = sram_test_pkg::lfsr_next(seed_q);
               state_nxt = sram_test_pkg::tst_read;
            end else begin
               acc_wr = 1'b1;
               sm_addr_nxt = sm_addr + 1'b1;
               pat_nxt = sram_test_pkg::lfsr_next(pat);
            end
         end
         sram_test_pkg::tst_read: begin
            if (sm_addr != sram_test_pkg::stop_addr) begin
               acc_vld = 1'b1;
               sm_addr_nxt = sm_addr + 1'b1;
               pat_nxt = sram_test_pkg::lfsr_next(pat);
            end
            fail_nxt = tst_fail | chk_fail;
            if (last_rd) begin
               done_nxt = 1'b1;
               state_nxt = sram_test_pkg::tst_idle;
            end
         end
         default: begin
            state_nxt = sram_test_pkg::tst_idle;
         end
      endcase
   end

   // write data and bus enable two cycles after the address
   assign wr_stage = pipe_vld[2-1] & ~pipe_rd[2-1];

   // read compare at the last stage
   assign chk_vld = pipe_vld[lat] & pipe_rd[lat];
   assign chk_fail = chk_vld & (rd_data != pipe_data[lat]);
   assign last_rd = chk_vld & (pipe_addr[lat] == sram_test_pkg::stop_addr);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= sram_test_pkg::tst_idle;
         sm_addr <= '0;
         we_n <= 1'b1;
         tri_en <= 1'b0;
         pipe_vld <= '0;
         tst_fail <= 1'b0;
         tst_done <= 1'b0;
         log_vld <= 1'b0;
      end else begin
         state <= state_nxt;
         sm_addr <= sm_addr_nxt;
         we_n <= ~(acc_vld & acc_wr);
         tri_en <= wr_stage;
         pipe_vld <= {pipe_vld[lat-1:0], acc_vld};
         tst_fail <= fail_nxt;
         tst_done <= done_nxt;
         log_vld <= chk_fail;
      end
   end

   ////////////////////////////////////////
   // pipeline payload
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      addr <= sm_addr_nxt;
      wr_data <= wr_stage ? pipe_data[2-1] : '0;
      pat <= pat_nxt;
      if (state == sram_test_pkg::tst_idle && tst_start) begin
         seed_q <= tst_seed;
      end
      pipe_rd <= {pipe_rd[lat-1:0], ~acc_wr};
      pipe_addr[0] <= sm_addr_nxt;
      pipe_data[0] <= acc_data;
      for (int i = lat; i > 0; i--) begin
         pipe_addr[i] <= pipe_addr[i-1];
         pipe_data[i] <= pipe_data[i-1];
      end
      // record fields only matter with log_vld
      log_addr <= pipe_addr[lat];
      log_exp_data <= pipe_data[lat];
      log_rd_data <= rd_data;
   end

endmodule

`default_nettype wire

/* hdl/sram_error_log.sv */
// mismatch record fifo drained by the host
// saturating counters for all mismatches and for dropped records
`timescale 1ns/1ns
`default_nettype none

module sram_error_log (
   input  wire logic                                   clk,
   input  wire logic                                   reset,
   input  wire logic                                   run_clear,
   input  wire logic                                   log_vld,
   input  wire logic [sram_test_pkg::sram_addr_w-1:0]  log_addr,
   input  wire logic [sram_test_pkg::sram_data_w-1:0]  log_exp_data,
   input  wire logic [sram_test_pkg::sram_data_w-1:0]  log_rd_data,
   output logic                                        err_vld,
   output logic [sram_test_pkg::sram_addr_w-1:0]       err_addr,
   output logic [sram_test_pkg::sram_data_w-1:0]       err_exp_data,
   output logic [sram_test_pkg::sram_data_w-1:0]       err_rd_data,
   input  wire logic                                   err_pop,
   output logic [sram_test_pkg::log_cnt_w-1:0]         err_count,
   output logic [sram_test_pkg::log_cnt_w-1:0]         ovf_count
);

   logic [sram_test_pkg::sram_addr_w-1:0]  mem_addr [0:sram_test_pkg::log_depth-1];
   logic [sram_test_pkg::sram_data_w-1:0]  mem_exp [0:sram_test_pkg::log_depth-1];
   logic [sram_test_pkg::sram_data_w-1:0]  mem_rd [0:sram_test_pkg::log_depth-1];

   logic [sram_test_pkg::log_ptr_w-1:0]    wr_ptr;
   logic [sram_test_pkg::log_ptr_w-1:0]    rd_ptr;
   logic [sram_test_pkg::log_ptr_w:0]      used;
   logic                                   full;
   logic                                   push;
   logic                                   pop;

   assign full = (used == sram_test_pkg::log_depth);
   assign push = log_vld & ~full;
   assign pop = err_pop & err_vld;

   // oldest entry on the host side
   assign err_vld = (used != '0);
   assign err_addr = mem_addr[rd_ptr];
   assign err_exp_data = mem_exp[rd_ptr];
   assign err_rd_data = mem_rd[rd_ptr];

   always_ff @(posedge clk) begin
      if (reset || run_clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used <= '0;
         err_count <= '0;
         ovf_count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         used <= used + push - pop;
         // counters hold at all ones
         if (log_vld && err_count != '1) begin
            err_count <= err_count + 1'b1;
         end
         if (log_vld && full && ovf_count != '1) begin
            ovf_count <= ovf_count + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem_addr[wr_ptr] <= log_addr;
         mem_exp[wr_ptr] <= log_exp_data;
         mem_rd[wr_ptr] <= log_rd_data;
      end
   end

endmodule

`default_nettype wire

/* hdl/sram_test_top.sv */
// sram self-test top level
// controller, pattern tester and error log
// host control, log readout and sram pins
`timescale 1ns/1ns
`default_nettype none

module sram_test_top (
   input  wire logic                                   clk,
   input  wire logic                                   reset,
   // host control
   input  wire logic                                   start,
   input  wire logic [sram_test_pkg::sram_data_w-1:0]  seed,
   input  wire logic [sram_test_pkg::pass_cnt_w-1:0]   num_passes,
   output logic                                        busy,
   output logic                                        done,
   output logic                                        fail,
   output logic [sram_test_pkg::log_cnt_w-1:0]         pass_ok_count,
   output logic [sram_test_pkg::log_cnt_w-1:0]         pass_fail_count,
   // log readout
   output logic                                        err_vld,
   output logic [sram_test_pkg::sram_addr_w-1:0]       err_addr,
   output logic [sram_test_pkg::sram_data_w-1:0]       err_exp_data,
   output logic [sram_test_pkg::sram_data_w-1:0]       err_rd_data,
   input  wire logic                                   err_pop,
   output logic [sram_test_pkg::log_cnt_w-1:0]         err_count,
   output logic [sram_test_pkg::log_cnt_w-1:0]         ovf_count,
   // sram pins
   output logic [sram_test_pkg::sram_addr_w-1:0]       addr,
   output logic                                        we_n,
   output logic [sram_test_pkg::sram_data_w-1:0]       wr_data,
   output logic                                        tri_en,
   input  wire logic [sram_test_pkg::sram_data_w-1:0]  rd_data
);

   logic                                    tst_start;
   logic [sram_test_pkg::sram_data_w-1:0]   tst_seed;
   logic                                    tst_done;
   logic                                    tst_fail;
   logic                                    run_clear;
   logic                                    log_vld;
   logic [sram_test_pkg::sram_addr_w-1:0]   log_addr;
   logic [sram_test_pkg::sram_data_w-1:0]   log_exp_data;
   logic [sram_test_pkg::sram_data_w-1:0]   log_rd_data;

   sram_test_ctrl i_ctrl (
      .clk(clk), .reset(reset),
      .start(start), .seed(seed), .num_passes(num_passes),
      .busy(busy), .done(done), .fail(fail),
      .pass_ok_count(pass_ok_count), .pass_fail_count(pass_fail_count),
      .tst_start(tst_start), .tst_seed(tst_seed),
      .tst_done(tst_done), .tst_fail(tst_fail), .run_clear(run_clear)
   );

   sram_rand_pat_tester i_tester (
      .clk(clk), .reset(reset),
      .tst_start(tst_start), .tst_seed(tst_seed),
      .tst_done(tst_done), .tst_fail(tst_fail),
      .addr(addr), .we_n(we_n), .wr_data(wr_data), .tri_en(tri_en), .rd_data(rd_data),
      .log_vld(log_vld), .log_addr(log_addr),
      .log_exp_data(log_exp_data), .log_rd_data(log_rd_data)
   );

   sram_error_log i_log (
      .clk(clk), .reset(reset), .run_clear(run_clear),
      .log_vld(log_vld), .log_addr(log_addr),
      .log_exp_data(log_exp_data), .log_rd_data(log_rd_data),
      .err_vld(err_vld), .err_addr(err_addr),
      .err_exp_data(err_exp_data), .err_rd_data(err_rd_data),
      .err_pop(err_pop), .err_count(err_count), .ovf_count(ovf_count)
   );

endmodule

`default_nettype wire

/* testbench/sram_model.sv */
// behavioral pipelined sram for the self-test
// write data two cycles and read data rd_latency cycles after the address
// stuck-bit fault over a masked address range
`timescale 1ns/1ns
`default_nettype none

module sram_model (
   input  wire logic                                   clk,
   input  wire logic [sram_test_pkg::sram_addr_w-1:0]  addr,
   input  wire logic                                   we_n,
   input  wire logic [sram_test_pkg::sram_data_w-1:0]  wr_data,
   input  wire logic                                   tri_en,
   output logic [sram_test_pkg::sram_data_w-1:0]       rd_data,
   input  wire logic                                   fault_en,
   input  wire logic [sram_test_pkg::sram_addr_w-1:0]  fault_addr,
   input  wire logic [sram_test_pkg::sram_addr_w-1:0]  fault_mask,
   input  wire logic [5:0]                             fault_bit,
   input  wire logic                                   fault_val
);

   localparam int lat = sram_test_pkg::rd_latency;

   logic [sram_test_pkg::sram_data_w-1:0]   mem [0:255];
   logic [sram_test_pkg::sram_addr_w-1:0]   a_q [0:lat-2];
   logic [1:0]                              wr_q;
   logic [sram_test_pkg::sram_data_w-1:0]   word;

   initial begin
      rd_data = '0;
      wr_q = '0;
      // fill depends on the whole address
      for (int i = 0; i < 256; i++) begin
         mem[i] = {4'h5, i[7:0], ~i[7:0], i[7:0], ~i[7:0]};
      end
   end

   always @(posedge clk) begin
      a_q[0] <= addr;
      wr_q <= {wr_q[0], ~we_n};
      for (int i = 1; i < lat - 1; i++) begin
         a_q[i] <= a_q[i-1];
      end
      // bus is driven two cycles after the write address
      if (wr_q[1] === 1'b1 && tri_en === 1'b1) begin
         mem[a_q[1]] <= wr_data;
      end
      word = mem[a_q[lat-2]];
      if (fault_en && ((a_q[lat-2] & fault_mask) == (fault_addr & fault_mask))) begin
         word[fault_bit] = fault_val;
      end
      rd_data <= word;
   end

endmodule

`default_nettype wire

/* testbench/sram_test_asserts.sv */
// concurrent checks on the sram pins and the error log
// bound into the self-test top level
`timescale 1ns/1ns
`default_nettype none

module sram_test_asserts (
   input wire logic clk,
   input wire logic reset,
   input wire logic we_n,
   input wire logic tri_en,
   input wire logic log_vld,
   input wire logic run_clear,
   input wire logic err_vld,
   input wire logic err_pop
);

   int failures = 0;

   // bus driven only two cycles after a write address
   bus_drive_on_write: assert property (@(posedge clk) disable iff (reset)
      tri_en |-> !$past(we_n, 2))
   else begin
      $error("tri_en high two cycles after a read address");
      failures++;
   end

   // log turns non-empty only from a record one cycle earlier
   err_vld_from_record: assert property (@(posedge clk) disable iff (reset)
      $rose(err_vld) |-> $past(log_vld))
   else begin
      $error("err_vld rose without a record from the tester");
      failures++;
   end

   // head entry holds until popped or cleared
   err_vld_held: assert property (@(posedge clk) disable iff (reset)
      (err_vld && !err_pop && !run_clear) |=> err_vld)
   else begin
      $error("err_vld dropped without a pop");
      failures++;
   end

endmodule

bind sram_test_top sram_test_asserts i_asserts (
   .clk(clk), .reset(reset), .we_n(we_n), .tri_en(tri_en), .log_vld(log_vld),
   .run_clear(run_clear), .err_vld(err_vld), .err_pop(err_pop)
);

`default_nettype wire

/* testbench/sram_test_tb.sv */
// testbench for the sram self-test
// xorshift stimulus, reference model of pattern chain and stuck-bit fault
// log readout checks and final report
`timescale 1ns/1ns
`default_nettype none

module sram_test_tb;

   logic                                    clk;
   logic                                    reset;
   logic                                    start;
   logic [sram_test_pkg::sram_data_w-1:0]   seed;
   logic [sram_test_pkg::pass_cnt_w-1:0]    num_passes;
   logic                                    busy;
   logic                                    done;
   logic                                    fail;
   logic [sram_test_pkg::log_cnt_w-1:0]     pass_ok_count;
   logic [sram_test_pkg::log_cnt_w-1:0]     pass_fail_count;
   logic                                    err_vld;
   logic [sram_test_pkg::sram_addr_w-1:0]   err_addr;
   logic [sram_test_pkg::sram_data_w-1:0]   err_exp_data;
   logic [sram_test_pkg::sram_data_w-1:0]   err_rd_data;
   logic                                    err_pop;
   logic [sram_test_pkg::log_cnt_w-1:0]     err_count;
   logic [sram_test_pkg::log_cnt_w-1:0]     ovf_count;
   logic [sram_test_pkg::sram_addr_w-1:0]   addr;
   logic                                    we_n;
   logic [sram_test_pkg::sram_data_w-1:0]   wr_data;
   logic                                    tri_en;
   logic [sram_test_pkg::sram_data_w-1:0]   rd_data;
   logic                                    fault_en;
   logic [sram_test_pkg::sram_addr_w-1:0]   fault_addr;
   logic [sram_test_pkg::sram_addr_w-1:0]   fault_mask;
   logic [5:0]                              fault_bit;
   logic                                    fault_val;

   logic [31:0]    rng;
   int             n_val_err;
   int             n_other_err;
   // record is {addr, expected word, read word}
   logic [79:0]    exp_q [$];
   int             exp_total;
   int             exp_bad_passes;
   logic [35:0]    run_seed;
   int             run_passes;

   sram_test_top i_dut (.*);
   sram_model i_sram (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // shift left, b35 ^ b24 ^ nor of b34..b0 comes in at the bottom
   function automatic logic [35:0] pattern_step(input logic [35:0] w);
      return {w[34:0], w[35] ^ w[24] ^ ~(|w[34:0])};
   endfunction

   function automatic bit fault_hit(input int a);
      return fault_en && ((8'(a) & fault_mask) == (fault_addr & fault_mask));
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         n_val_err++;
      end
   endtask

   task automatic pick_run();
      rng = xorshift32(rng);
      run_passes = 1 + rng % 3;
      run_seed[35:32] = rng[31:28];
      rng = xorshift32(rng);
      run_seed[31:0] = rng;
   endtask

   task automatic pick_fault();
      rng = xorshift32(rng);
      fault_addr = rng[7:0];
      fault_bit = 6'(rng[15:8] % 36);
      fault_val = rng[16];
   endtask

   // mismatch records of a whole run, in pass then address order
   task automatic build_expected(input logic [35:0] s, input int passes, input bit keep_all);
      logic [35:0] w;
      logic [35:0] bad;
      bit pass_bad;
      exp_q.delete();
      exp_total = 0;
      exp_bad_passes = 0;
      for (int k = 0; k < passes; k++) begin
         w = s;
         pass_bad = 1'b0;
         for (int a = 0; a < 256; a++) begin
            bad = w;
            bad[fault_bit] = fault_val;
            if (fault_hit(a) && bad != w) begin
               exp_total++;
               pass_bad = 1'b1;
               if (keep_all || exp_q.size() < sram_test_pkg::log_depth) begin
                  exp_q.push_back({8'(a), w, bad});
               end
            end
            w = pattern_step(w);
         end
         exp_bad_passes += pass_bad;
         s = pattern_step(s);
      end
   endtask

   // compare the head entry and request its removal
   task automatic pop_entry();
      logic [79:0] rec;
      if (exp_q.size() == 0) begin
         $display("log holds an entry for address %0h that no fault explains", err_addr);
         n_other_err++;
      end else begin
         rec = exp_q.pop_front();
         check_value("err_addr", err_addr, rec[79:72]);
         check_value("err_exp_data", err_exp_data, rec[71:36]);
         check_value("err_rd_data", err_rd_data, rec[35:0]);
      end
      err_pop = 1'b1;
   endtask

   task automatic run_test(input logic [35:0] s, input int passes, input bit pop_live,
                           input bit drain, input bit poke_busy);
      int cyc;
      seed = s;
      num_passes = 4'(passes);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      check_value("busy", busy, 1);
      cyc = 0;
      while (!done && cyc < 600 * passes + 50) begin
         rng = xorshift32(rng);
         err_pop = 1'b0;
         // log is cleared two cycles after start
         if (pop_live && cyc >= 2 && err_vld && rng[0]) begin
            pop_entry();
         end
         if (poke_busy && cyc == 50) begin
            start = 1'b1;
            seed = ~s;
            num_passes = 4'd9;
         end else begin
            start = 1'b0;
         end
         @(negedge clk);
         cyc++;
      end
      err_pop = 1'b0;
      start = 1'b0;
      if (!done) begin
         $display("timeout: done did not arrive within %0d cycles", cyc);
         n_other_err++;
         return;
      end
      check_value("fail", fail, exp_bad_passes != 0);
      check_value("pass_ok_count", pass_ok_count, passes - exp_bad_passes);
      check_value("pass_fail_count", pass_fail_count, exp_bad_passes);
      check_value("err_count", err_count, exp_total);
      check_value("ovf_count", ovf_count, (!pop_live && exp_total > sram_test_pkg::log_depth) ?
                  exp_total - sram_test_pkg::log_depth : 0);
      if (drain) begin
         cyc = 0;
         while (err_vld && cyc < 2 * sram_test_pkg::log_depth) begin
            pop_entry();
            @(negedge clk);
            err_pop = 1'b0;
            cyc++;
         end
         check_value("err_vld", err_vld, 0);
         if (exp_q.size() != 0) begin
            $display("%0d expected log records never showed up", exp_q.size());
            n_other_err++;
         end
      end
      if (poke_busy) begin
         repeat (4) @(negedge clk);
         check_value("busy", busy, 0);
      end
   endtask

   initial begin
      rng = 32'h240f69ae;
      n_val_err = 0;
      n_other_err = 0;
      reset = 1'b1;
      start = 1'b0;
      seed = '0;
      num_passes = '0;
      err_pop = 1'b0;
      fault_en = 1'b0;
      fault_addr = '0;
      fault_mask = 8'hff;
      fault_bit = '0;
      fault_val = 1'b0;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      // fault-free runs
      repeat (2) begin
         pick_run();
         build_expected(run_seed, run_passes, 1'b1);
         run_test(run_seed, run_passes, 1'b1, 1'b1, 1'b0);
      end

      // one stuck bit at one address
      fault_en = 1'b1;
      repeat (3) begin
         pick_run();
         pick_fault();
         build_expected(run_seed, run_passes, 1'b1);
         run_test(run_seed, run_passes, 1'b1, 1'b1, 1'b0);
      end

      // seed chain over three passes, block of four faulty words
      fault_mask = 8'hfc;
      pick_run();
      pick_fault();
      build_expected(run_seed, 3, 1'b1);
      run_test(run_seed, 3, 1'b1, 1'b1, 1'b0);

      // every address faulty, nothing popped until done
      fault_mask = 8'h00;
      pick_run();
      pick_fault();
      build_expected(run_seed, run_passes, 1'b0);
      run_test(run_seed, run_passes, 1'b0, 1'b1, 1'b0);

      // full log left behind, then a clean run with a start while busy
      pick_run();
      build_expected(run_seed, run_passes, 1'b0);
      run_test(run_seed, run_passes, 1'b0, 1'b0, 1'b0);
      fault_en = 1'b0;
      pick_run();
      build_expected(run_seed, run_passes, 1'b1);
      run_test(run_seed, run_passes, 1'b1, 1'b1, 1'b1);

      $display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
               n_val_err, n_other_err, i_dut.i_asserts.failures);
      if (n_val_err == 0 && n_other_err == 0 && i_dut.i_asserts.failures == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sram_test_top.f */
hdl/sram_test_pkg.sv
hdl/sram_test_ctrl.sv
hdl/sram_rand_pat_tester.sv
hdl/sram_error_log.sv
hdl/sram_test_top.sv
testbench/sram_model.sv
testbench/sram_test_asserts.sv
testbench/sram_test_tb.sv
